// File: common/dfpPkg.sv
/* shared formats and constants for the decimal floating point normalizer,
   imported by the RTL and the testbench */
package dfpPkg;

	// result mantissa digits below the single whole digit
	localparam int NormDigits = 8;

	// intermediate format has two whole digits and twice the fraction
	localparam int WideDigits = 2 * (NormDigits + 1);

	// working mantissa: result digits plus one sticky digit at the bottom
	localparam int WorkDigits = NormDigits + 2;

	// exponent of all nines marks infinity or NaN
	localparam logic [15:0] ExpMax = 16'h9999;

	// four BCD digit exponent magnitude
	typedef logic [15:0] bcdExp_t;

	// working mantissa passed between the pipeline stages
	typedef logic [WorkDigits*4-1:0] workMan_t;

	// widened intermediate input, top two mantissa digits are whole digits
	typedef struct packed {
		logic nan;
		logic sign;
		logic inf;
		logic expNeg;
		bcdExp_t exp;
		logic [WideDigits*4-1:0] man;
	} dfpWide_t;

	// normalized result with one whole digit
	typedef struct packed {
		logic nan;
		logic sign;
		logic inf;
		logic expNeg;
		bcdExp_t exp;
		logic [(NormDigits+1)*4-1:0] man;
		logic sticky;
	} dfpNorm_t;

endpackage

// File: logic/bcdAddSub.sv
/* four digit BCD adder and subtractor, used for the exponent updates */
`timescale 1ns/10ps

module bcdAddSub
	import dfpPkg::*;
(
	input  bcdExp_t a_i,
	input  bcdExp_t b_i,
	input  logic    sub_i,
	output bcdExp_t sum_o,
	output logic    carry_o
);

	localparam int Digits = $bits(bcdExp_t) / 4;

	// ripple through the digits with decimal correction
	// subtraction adds the nines complement with a carry in
	always_comb begin
		logic c;
		logic [3:0] bDigit;
		logic [4:0] s;
		c = sub_i;
		sum_o = '0;
		for (int i = 0; i < Digits; i++) begin
			bDigit = sub_i ? 4'd9 - b_i[i*4 +: 4] : b_i[i*4 +: 4];
			s = {1'b0, a_i[i*4 +: 4]} + {1'b0, bDigit} + {4'b0, c};
			// digit overflow, skip the six unused codes
			if (s > 5'd9) begin
				s = s + 5'd6;
				c = 1'b1;
			end else begin
				c = 1'b0;
			end
			sum_o[i*4 +: 4] = s[3:0];
		end
		// carry out on add, borrow out on subtract
		carry_o = sub_i ? ~c : c;
	end

endmodule

// File: logic/delayLine.sv
/* enabled register chain of selectable depth and payload type, cleared on reset */
`timescale 1ns/10ps

module delayLine #(
	parameter int Depth = 1,
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rstN_i,
	input  logic     ce_i,
	input  payload_t d_i,
	output payload_t q_o
);

	payload_t stages [Depth];

	// every tap holds while the enable is low
	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			for (int i = 0; i < Depth; i++)
				stages[i] <= '0;
		end else if (ce_i) begin
			stages[0] <= d_i;
			for (int i = 1; i < Depth; i++)
				stages[i] <= stages[i-1];
		end
	end

	assign q_o = stages[Depth-1];

endmodule

// File: normalize/digitLzc.sv
/* leading zero digit count of the working mantissa, purely combinational */
`timescale 1ns/10ps

module digitLzc
	import dfpPkg::*;
(
	input  workMan_t   man_i,
	output logic [4:0] count_o
);

	// scan from the top digit down, stop at the first nonzero one
	// an all zero mantissa counts every digit
	always_comb begin
		logic found;
		found = 1'b0;
		count_o = '0;
		for (int i = WorkDigits - 1; i >= 0; i--) begin
			if (!found) begin
				if (man_i[i*4 +: 4] != 4'h0)
					found = 1'b1;
				else
					count_o = count_o + 5'd1;
			end
		end
	end

endmodule

// File: normalize/dfpNormalize.sv
/* eight stage decimal floating point normalizer, reduces to one whole digit and
   shifts left by leading zeros, or right on underflow; NaN and infinity pass */
`timescale 1ns/10ps

module dfpNormalize
	import dfpPkg::*;
(
	input  logic     clk,
	input  logic     rstN_i,
	input  logic     ce_i,
	input  dfpWide_t in_i,
	input  logic     under_i,
	output dfpNorm_t out_o,
	output logic     under_o,
	output logic     inexact_o
);

	localparam int WideBits = WideDigits * 4;
	localparam int WorkBits = WorkDigits * 4;
	localparam int ResBits = (NormDigits + 1) * 4;
	// shift counts never exceed the working digit count
	localparam int ShiftW = $clog2(WorkDigits + 1);

	typedef struct packed {
		logic nan;
		logic sign;
		logic inf;
		logic expNeg;
	} sideFlags_t;

	logic xInf1, xInf5, xInf6;
	logic incExp2, incExp3;
	logic under6, under7;
	logic inexact4;
	logic [4:0] lzc4, lzc5;
	logic [13:0] expBin5;
	logic [ShiftW-1:0] lshift6, rshift6;
	logic rightSticky6, sticky7, sticky8;
	bcdExp_t exp2, expInc2, exp3, exp5, exp6, lshiftBcd6, expDec6, exp7, exp8;
	dfpWide_t wide1, wide3;
	workMan_t man4, man5, man6, manL7, manR7, manSel7;
	logic [ResBits-1:0] man8;
	sideFlags_t flags0, flags8;

	// side fields never change, they just ride along
	assign flags0 = '{nan: in_i.nan, sign: in_i.sign, inf: in_i.inf, expNeg: in_i.expNeg};
	delayLine #(.Depth(8), .payload_t(sideFlags_t)) flagsDly (
		.clk, .rstN_i, .ce_i, .d_i(flags0), .q_o(flags8));
	delayLine #(.Depth(6), .payload_t(logic)) under6Dly (
		.clk, .rstN_i, .ce_i, .d_i(under_i), .q_o(under6));
	delayLine #(.Depth(1), .payload_t(logic)) under7Dly (
		.clk, .rstN_i, .ce_i, .d_i(under6), .q_o(under7));
	delayLine #(.Depth(1), .payload_t(logic)) underODly (
		.clk, .rstN_i, .ce_i, .d_i(under7), .q_o(under_o));

	// --------------------
	// stage 1, exponent compares
	// treat a flagged NaN or infinity like an all nines exponent
	always_ff @(posedge clk) begin
		if (!rstN_i)
			xInf1 <= 1'b0;
		else if (ce_i)
			xInf1 <= in_i.exp == ExpMax || in_i.nan || in_i.inf;
	end
	delayLine #(.Depth(1), .payload_t(dfpWide_t)) wide1Dly (
		.clk, .rstN_i, .ce_i, .d_i(in_i), .q_o(wide1));

	// --------------------
	// stage 2, increment decision
	// a nonzero top whole digit needs one more exponent step
	always_ff @(posedge clk) begin
		if (!rstN_i)
			incExp2 <= 1'b0;
		else if (ce_i)
			incExp2 <= !xInf1 && wide1.man[WideBits-1 -: 4] != 4'h0;
	end
	delayLine #(.Depth(1), .payload_t(bcdExp_t)) exp2Dly (
		.clk, .rstN_i, .ce_i, .d_i(wide1.exp), .q_o(exp2));
	delayLine #(.Depth(2), .payload_t(dfpWide_t)) wide3Dly (
		.clk, .rstN_i, .ce_i, .d_i(wide1), .q_o(wide3));

	// --------------------
	// stage 3, BCD increment
	bcdAddSub incAdd (
		.a_i(exp2), .b_i(16'h0001), .sub_i(1'b0), .sum_o(expInc2), .carry_o());

	always_ff @(posedge clk) begin
		if (!rstN_i)
			exp3 <= '0;
		else if (ce_i)
			exp3 <= incExp2 ? expInc2 : exp2;
	end
	delayLine #(.Depth(1), .payload_t(logic)) incExp3Dly (
		.clk, .rstN_i, .ce_i, .d_i(incExp2), .q_o(incExp3));

	// --------------------
	// stage 4, drop to one whole digit
	// low digits fold into the sticky digit, which also flags inexact
	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			man4 <= '0;
			inexact4 <= 1'b0;
		end else if (ce_i) begin
			if (incExp3) begin
				man4 <= {wide3.man[WideBits-1 -: ResBits], 3'b0, |wide3.man[ResBits-1:0]};
				inexact4 <= |wide3.man[ResBits-1:0];
			end else begin
				man4 <= {wide3.man[WideBits-5 -: ResBits], 3'b0,
					|wide3.man[NormDigits*4-1:0]};
				inexact4 <= |wide3.man[NormDigits*4-1:0];
			end
		end
	end
	delayLine #(.Depth(4), .payload_t(logic)) inexactDly (
		.clk, .rstN_i, .ce_i, .d_i(inexact4), .q_o(inexact_o));
	delayLine #(.Depth(2), .payload_t(bcdExp_t)) exp5Dly (
		.clk, .rstN_i, .ce_i, .d_i(exp3), .q_o(exp5));
	delayLine #(.Depth(4), .payload_t(logic)) xInf5Dly (
		.clk, .rstN_i, .ce_i, .d_i(xInf1), .q_o(xInf5));

	// --------------------
	// stage 5, leading digit count
	digitLzc lzc (.man_i(man4), .count_o(lzc4));

	always_ff @(posedge clk) begin
		if (!rstN_i)
			lzc5 <= '0;
		else if (ce_i)
			lzc5 <= lzc4;
	end
	delayLine #(.Depth(1), .payload_t(workMan_t)) man5Dly (
		.clk, .rstN_i, .ce_i, .d_i(man4), .q_o(man5));

	// --------------------
	// stage 6, shift amounts in digits
	assign expBin5 = 14'(exp5[3:0]) + 14'(exp5[7:4]) * 14'd10
		+ 14'(exp5[11:8]) * 14'd100 + 14'(exp5[15:12]) * 14'd1000;

	// left shift stops at exponent zero, right shift is capped at the digit count
	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			lshift6 <= '0;
			rshift6 <= '0;
		end else if (ce_i) begin
			if (xInf5)
				lshift6 <= '0;
			else if (14'(lzc5) > expBin5)
				lshift6 <= ShiftW'(expBin5);
			else
				lshift6 <= ShiftW'(lzc5);
			if (xInf5)
				rshift6 <= '0;
			else if (expBin5 > 14'(NormDigits))
				rshift6 <= ShiftW'(NormDigits);
			else
				rshift6 <= ShiftW'(expBin5);
		end
	end
	delayLine #(.Depth(1), .payload_t(bcdExp_t)) exp6Dly (
		.clk, .rstN_i, .ce_i, .d_i(exp5), .q_o(exp6));
	delayLine #(.Depth(1), .payload_t(workMan_t)) man6Dly (
		.clk, .rstN_i, .ce_i, .d_i(man5), .q_o(man6));
	delayLine #(.Depth(1), .payload_t(logic)) xInf6Dly (
		.clk, .rstN_i, .ce_i, .d_i(xInf5), .q_o(xInf6));

	// --------------------
	// stage 7, exponent decrement and both shifts
	always_comb begin
		lshiftBcd6 = '0;
		lshiftBcd6[3:0] = 4'(lshift6 % 10);
		lshiftBcd6[7:4] = 4'(lshift6 / 10);
	end

	bcdAddSub decSub (
		.a_i(exp6), .b_i(lshiftBcd6), .sub_i(1'b1), .sum_o(expDec6), .carry_o());

	// anything below the right shift point is lost into sticky
	always_comb begin
		workMan_t lostMask;
		lostMask = (workMan_t'(1) << {rshift6, 2'b00}) - workMan_t'(1);
		rightSticky6 = |(man6 & lostMask);
	end

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			exp7 <= '0;
			manL7 <= '0;
			manR7 <= '0;
			sticky7 <= 1'b0;
		end else if (ce_i) begin
			// underflow lands exactly on exponent zero
			exp7 <= xInf6 ? exp6 : under6 ? bcdExp_t'(0) : expDec6;
			// sticky digit is cleared so it never enters the mantissa
			manL7 <= {man6[WorkBits-1:4], 4'h0} << {lshift6, 2'b00};
			manR7 <= man6 >> {rshift6, 2'b00};
			sticky7 <= under6 ? rightSticky6 : man6[0];
		end
	end

	// --------------------
	// stage 8, pick the shift direction
	assign manSel7 = under7 ? manR7 : manL7;

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			exp8 <= '0;
			man8 <= '0;
			sticky8 <= 1'b0;
		end else if (ce_i) begin
			exp8 <= exp7;
			man8 <= manSel7[WorkBits-1:4];
			// a digit pushed into the bottom slot also counts as lost
			sticky8 <= sticky7 | (|manSel7[3:0]);
		end
	end

	always_comb begin
		out_o.nan = flags8.nan;
		out_o.sign = flags8.sign;
		out_o.inf = flags8.inf;
		out_o.expNeg = flags8.expNeg;
		out_o.exp = exp8;
		out_o.man = man8;
		out_o.sticky = sticky8;
	end

endmodule

// File: logic/dfpNormTop.sv
/* subsystem top of the decimal normalizer, wraps the pipeline and
   presents its ports to the outside */
`timescale 1ns/10ps

module dfpNormTop
	import dfpPkg::*;
(
	input  logic     clk,
	input  logic     rstN_i,
	// level enable, low freezes every stage
	input  logic     ce_i,
	input  dfpWide_t in_i,
	input  logic     under_i,
	output dfpNorm_t out_o,
	output logic     under_o,
	output logic     inexact_o
);

	// eight enabled cycles from input to output
	dfpNormalize norm (
		.clk       (clk),
		.rstN_i    (rstN_i),
		.ce_i      (ce_i),
		.in_i      (in_i),
		.under_i   (under_i),
		.out_o     (out_o),
		.under_o   (under_o),
		.inexact_o (inexact_o)
	);

endmodule

// File: test/dfpNormTb.sv
/* testbench for the decimal normalizer top, reads vectors from the stim file and
   drives them with random enable gaps, checking each result in order */
`timescale 1ns/10ps

module dfpNormTb
	import dfpPkg::*;
();

	localparam int IssueLimit = 2000;
	localparam int DrainLimit = 200;

	logic clk = 1'b0;
	logic rstN, ce, underIn, underOut, inexactOut;
	dfpWide_t inWide;
	dfpNorm_t outNorm;

	// vector table, filled from the stim file
	dfpWide_t vecIn[$];
	logic vecUnder[$];
	dfpNorm_t vecOut[$];
	logic vecUnderOut[$];
	logic vecInexact[$];

	// model of the pipeline, vector index per enabled stage, -1 for idle
	int track[8];
	int issuedIdx, nextIdx, checked;
	int normErrors, flagErrors, otherErrors;
	logic ceDriven;
	logic [31:0] lfsr;

	dfpNormTop dfpNormTop_inst (
		.clk(clk), .rstN_i(rstN), .ce_i(ce), .in_i(inWide), .under_i(underIn),
		.out_o(outNorm), .under_o(underOut), .inexact_o(inexactOut));

	always #10 clk = ~clk;

	// --------------------
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic drawBit(output logic b);
		lfsr = lfsrNext(lfsr);
		b = lfsr[0];
	endtask

	// columns: in flags, exp, man, under, out flags, exp, man, sticky, under, inexact
	task automatic loadVectors();
		int fd;
		int got;
		string line;
		logic [3:0] inFlags, outFlags;
		bcdExp_t inExp, outExp;
		logic [WideDigits*4-1:0] inMan;
		logic [(NormDigits+1)*4-1:0] outMan;
		logic inUnder, outSticky, outUnder, outInexact;
		fd = $fopen("test/normStim.txt", "r");
		if (fd == 0) begin
			$display("could not open stimulus file test/normStim.txt");
			otherErrors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			// skip comment and empty lines
			if (line.len() > 1 && line[0] != "#") begin
				got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", inFlags, inExp, inMan,
					inUnder, outFlags, outExp, outMan, outSticky, outUnder, outInexact);
				if (got != 10) begin
					$display("malformed stimulus line: %s", line);
					otherErrors++;
				end else begin
					vecIn.push_back(dfpWide_t'({inFlags, inExp, inMan}));
					vecUnder.push_back(inUnder);
					vecOut.push_back(dfpNorm_t'({outFlags, outExp, outMan, outSticky}));
					vecUnderOut.push_back(outUnder);
					vecInexact.push_back(outInexact);
				end
			end
		end
		$fclose(fd);
	endtask

	// --------------------
	// one error per wrong result, one line per wrong field
	task automatic checkNorm(input dfpNorm_t got, input dfpNorm_t want, input int idx);
		if (got !== want) begin
			normErrors++;
			if ({got.nan, got.sign, got.inf, got.expNeg}
				!== {want.nan, want.sign, want.inf, want.expNeg})
				$display("Mismatch at %0t: vector %0d flags got %b expected %b", $time, idx,
					{got.nan, got.sign, got.inf, got.expNeg},
					{want.nan, want.sign, want.inf, want.expNeg});
			if (got.exp !== want.exp)
				$display("Mismatch at %0t: vector %0d exp got %h expected %h", $time, idx,
					got.exp, want.exp);
			if (got.man !== want.man)
				$display("Mismatch at %0t: vector %0d man got %h expected %h", $time, idx,
					got.man, want.man);
			if (got.sticky !== want.sticky)
				$display("Mismatch at %0t: vector %0d sticky got %b expected %b", $time, idx,
					got.sticky, want.sticky);
		end
	endtask

	task automatic checkFlag(input logic got, input logic want, input string name,
		input int idx);
		if (got !== want) begin
			flagErrors++;
			$display("Mismatch at %0t: vector %0d %s got %b expected %b", $time, idx, name,
				got, want);
		end
	endtask

	// idle slots, reset included, must come out all zero
	task automatic checkOutput(input int idx);
		dfpNorm_t wantNorm;
		logic wantUnder, wantInexact;
		wantNorm = '0;
		wantUnder = 1'b0;
		wantInexact = 1'b0;
		if (idx >= 0) begin
			wantNorm = vecOut[idx];
			wantUnder = vecUnderOut[idx];
			wantInexact = vecInexact[idx];
			checked++;
		end
		checkNorm(outNorm, wantNorm, idx);
		checkFlag(underOut, wantUnder, "under_o", idx);
		checkFlag(inexactOut, wantInexact, "inexact_o", idx);
	endtask

	// --------------------
	// one clock, check after an enabled edge then drive the next inputs
	task automatic runCycle();
		logic gapA, gapB;
		logic ceNext;
		@(posedge clk);
		if (ceDriven) begin
			for (int i = 7; i > 0; i--)
				track[i] = track[i-1];
			track[0] = issuedIdx;
		end
		#2;
		if (ceDriven)
			checkOutput(track[7]);
		// enable drops when both bits are set, about one cycle in four
		drawBit(gapA);
		drawBit(gapB);
		ceNext = !(gapA && gapB);
		if (!ceNext) begin
			// junk on the inputs while frozen must not get in
			inWide = ~inWide;
			underIn = ~underIn;
		end else if (nextIdx < vecIn.size()) begin
			inWide = vecIn[nextIdx];
			underIn = vecUnder[nextIdx];
			issuedIdx = nextIdx;
			nextIdx++;
		end else begin
			inWide = '0;
			underIn = 1'b0;
			issuedIdx = -1;
		end
		ce = ceNext;
		ceDriven = ceNext;
	endtask

	initial begin
		int cycles;
		rstN = 1'b0;
		ce = 1'b1;
		inWide = '0;
		underIn = 1'b0;
		lfsr = 32'hce15_4ffc;
		for (int i = 0; i < 8; i++)
			track[i] = -1;
		ceDriven = 1'b1;
		issuedIdx = -1;
		nextIdx = 0;
		checked = 0;
		normErrors = 0;
		flagErrors = 0;
		otherErrors = 0;
		loadVectors();
		repeat (4) @(posedge clk);
		#2;
		rstN = 1'b1;
		if (vecIn.size() == 0) begin
			$display("no stimulus vectors were loaded");
			otherErrors++;
		end else begin
			for (cycles = 0; nextIdx < vecIn.size() && cycles < IssueLimit; cycles++)
				runCycle();
			if (nextIdx < vecIn.size()) begin
				$display("timeout while issuing vectors, %0d of %0d sent", nextIdx,
					vecIn.size());
				otherErrors++;
			end else begin
				// flush the pipeline with idle slots
				for (cycles = 0; checked < vecIn.size() && cycles < DrainLimit; cycles++)
					runCycle();
				if (checked < vecIn.size()) begin
					$display("timeout while draining, %0d of %0d results seen", checked,
						vecIn.size());
					otherErrors++;
				end
			end
		end
		$display("errors: result %0d, flag %0d, other %0d; vectors checked %0d of %0d",
			normErrors, flagErrors, otherErrors, checked, vecIn.size());
		if (normErrors + flagErrors + otherErrors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: test/normStim.txt
# in:  flags(nan sign inf expNeg) exp man(18 digits) under
# out: flags exp man(9 digits) sticky under inexact
# already normalized, then whole digit increments with carries and sticky
0 0100 012345678900000000 0   0 0100 123456789 0 0 0
0 0123 123456789000000000 0   0 0124 123456789 0 0 0
4 0999 987654321100000000 0   4 1000 987654321 1 0 1
1 1999 500000000000000003 0   1 2000 500000000 1 0 1
0 0009 900000000000000001 0   0 0010 900000000 1 0 1
0 0050 012345678900000070 0   0 0050 123456789 1 0 1
# left shifts, some stopped by the exponent
0 0020 000012300000000000 0   0 0017 123000000 0 0 0
0 0002 000001230000000000 0   0 0000 001230000 0 0 0
0 0000 000000500000000000 0   0 0000 000005000 0 0 0
0 0103 000000600000000090 0   0 0098 600000000 1 0 1
0 0005 000000000000000000 0   0 0000 000000000 0 0 0
0 0015 000000000000000000 0   0 0005 000000000 0 0 0
4 0001 000000000500000000 0   4 0000 000000050 0 0 0
0 0100 000000000700000000 0   0 0092 700000000 0 0 0
# underflow, right shift capped at eight digits
0 0003 012345678900000000 1   0 0000 000123456 1 1 0
5 0050 010000000000000000 1   5 0000 000000001 0 1 0
1 0000 001234567800000000 1   1 0000 012345678 0 1 0
1 0002 120000000000000050 1   1 0000 000120000 1 1 1
0 1234 098765432100000000 1   0 0000 000000009 1 1 0
# NaN, infinity and the all nines exponent pass through
8 1234 000012345000000000 0   8 1234 000123450 0 0 0
6 0042 001000000000000000 0   6 0042 010000000 0 0 0
0 9999 000500000000000000 0   0 9999 005000000 0 0 0
8 0500 001100000000000000 1   8 0500 011000000 0 1 0

// File: all.f
common/dfpPkg.sv
logic/bcdAddSub.sv
logic/delayLine.sv
normalize/digitLzc.sv
normalize/dfpNormalize.sv
logic/dfpNormTop.sv
test/dfpNormTb.sv

// File: Bender.yml
package:
  name: dfp_norm

dependencies: {}

sources:
  # shared package first
  - common/dfpPkg.sv
  # leaf blocks
  - logic/bcdAddSub.sv
  - logic/delayLine.sv
  - normalize/digitLzc.sv
  # normalizer pipeline and subsystem top
  - normalize/dfpNormalize.sv
  - logic/dfpNormTop.sv
  # testbench, reads test/normStim.txt at run time
  - target: test
    files:
      - test/dfpNormTb.sv

export_include_dirs: []

vendor_package: []

workspace: {}
